// ==== Makefile ====
# Verilator build and run for the trigger core testbench

VERILATOR ?= verilator
TOP       ?= wfd_trig_tb
FILELIST  ?= wfd_trig.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIMFLAGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	-./$(BUILD_DIR)/$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -x "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/fill_readout.sv ====
// fill readout to the DAQ link
`timescale 1ns/1ps
`default_nettype none

module fill_readout (
    input  wire                          clk125,
    input  wire                          arst_n,
    input  wire                          fifo_valid,
    input  wire wfd_trig_pkg::trig_rec_t fifo_rec,
    input  wire                          daq_ready,
    output logic                         fifo_ready,
    output logic                         daq_valid,
    output logic                         daq_header,   // first word of a fill
    output logic                         daq_trailer,  // last word of a fill
    output wfd_trig_pkg::daq_word_t      daq_data
);
    import wfd_trig_pkg::*;

    ro_state_t             state;
    trig_rec_t             rec_q;        // record of the fill in progress
    logic [CHAN_IDX_W-1:0] chan_idx;     // channel word being sent
    logic [WCNT_W-1:0]     wcnt;         // words accepted so far
    logic [CHAN_IDX_W:0]   nxt;          // msb set when no channel left
    logic                  xfer;
    hdr_word_t             hdr;
    chan_word_t            cw;
    trl_word_t             trl;

    // lowest enabled channel at or above start
    function automatic logic [CHAN_IDX_W:0] find_chan(input chan_mask_t mask, input int start);
        logic [CHAN_IDX_W:0] res;
        res = {1'b1, {CHAN_IDX_W{1'b0}}};
        for (int i = NUM_CHAN - 1; i >= 0; i--) begin
            if (mask[i] && (i >= start)) begin
                res = {1'b0, CHAN_IDX_W'(i)};
            end
        end
        return res;
    endfunction

    assign xfer        = daq_valid & daq_ready;   // word taken by the link
    assign fifo_ready  = (state == RO_IDLE);
    assign daq_valid   = (state != RO_IDLE);
    assign daq_header  = (state == RO_HEADER);
    assign daq_trailer = (state == RO_TRAILER);

    always_comb begin
        nxt = find_chan(rec_q.chan_en, (state == RO_HEADER) ? 0 : int'(chan_idx) + 1);
    end

    ////////////////////
    // sequencing, each step waits for the link
    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state    <= RO_IDLE;
            chan_idx <= '0;
            wcnt     <= '0;
        end else begin
            case (state)
                RO_IDLE: begin
                    if (fifo_valid) begin
                        state <= RO_HEADER;   // record popped this edge
                        wcnt  <= '0;
                    end
                end
                RO_HEADER, RO_CHAN: begin
                    if (xfer) begin
                        wcnt <= wcnt + 1'b1;
                        if (nxt[CHAN_IDX_W]) begin
                            state <= RO_TRAILER;   // mask exhausted
                        end else begin
                            chan_idx <= nxt[CHAN_IDX_W-1:0];
                            state    <= RO_CHAN;
                        end
                    end
                end
                RO_TRAILER: begin
                    if (xfer) begin
                        state <= RO_IDLE;
                    end
                end
                default: state <= RO_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk125) begin
        if (fifo_ready && fifo_valid) begin
            rec_q <= fifo_rec;
        end
    end

    ////////////////////
    // word packing, only registers feed it so it holds under a stall
    always_comb begin
        hdr = '{tag: HDR_TAG, rsvd: '0, chan_en: rec_q.chan_en, trig_num: rec_q.trig_num};
        cw  = '{tag: '0, rsvd: '0, chan_idx: chan_idx, trig_num: rec_q.trig_num};
        trl = '{tag: TRL_TAG, rsvd: '0, word_cnt: wcnt + 1'b1, trig_num: rec_q.trig_num};
        case (state)
            RO_HEADER:  daq_data = hdr;
            RO_CHAN:    daq_data = cw;
            RO_TRAILER: daq_data = trl;   // count includes the trailer
            default:    daq_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/trig_manager.sv ====
// trigger manager
`timescale 1ns/1ps
`default_nettype none

module trig_manager (
    input  wire                           clk125,
    input  wire                           arst_n,
    input  wire                           ext_trig,   // front panel, async
    input  wire wfd_trig_pkg::chan_mask_t acq_dones,  // from channels, async
    input  wire wfd_trig_pkg::chan_mask_t chan_en,    // static enables
    input  wire                           rec_ready,  // fifo has room
    output wfd_trig_pkg::chan_mask_t      acq_trigs,  // go pulse to channels
    output wfd_trig_pkg::chan_mask_t      trig_arm,
    output logic                          rec_valid,
    output wfd_trig_pkg::trig_rec_t       rec
);
    import wfd_trig_pkg::*;

    ////////////////////
    // synchronizers
    logic       trig_meta;
    logic       trig_sync;
    logic       trig_prev;       // for edge detect
    logic       trig_rise;
    chan_mask_t done_meta;
    chan_mask_t done_sync;

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            trig_meta <= 1'b0;
            trig_sync <= 1'b0;
            trig_prev <= 1'b0;
            done_meta <= '0;
            done_sync <= '0;
        end else begin
            trig_meta <= ext_trig;   // two flops into clk125
            trig_sync <= trig_meta;
            trig_prev <= trig_sync;
            done_meta <= acq_dones;
            done_sync <= done_meta;
        end
    end

    assign trig_rise = trig_sync & ~trig_prev;

    ////////////////////
    // arm / go / done fsm
    tm_state_t  state;
    trig_num_t  trig_cnt;        // next trigger number
    chan_mask_t en_snap;         // channels we wait on
    chan_mask_t done_low;        // done seen low since go
    logic       accept;
    logic       all_done;

    // only armed, with something enabled and room in the fifo
    assign accept = (state == TM_ARMED) && trig_rise && (chan_en != '0) && rec_ready;

    // a channel counts once its done dropped after go and came back high,
    // a stale done from the previous fill is not enough
    assign all_done = ((done_low & done_sync & en_snap) == en_snap);

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state     <= TM_ARMED;
            trig_cnt  <= '0;
            en_snap   <= '0;
            done_low  <= '0;
            acq_trigs <= '0;
            rec_valid <= 1'b0;
        end else begin
            acq_trigs <= accept ? chan_en : '0;   // one cycle go
            rec_valid <= accept;                  // ready known high, taken at once
            case (state)
                TM_ARMED: begin
                    if (accept) begin
                        state    <= TM_WAIT_DONE;
                        en_snap  <= chan_en;
                        done_low <= '0;
                        trig_cnt <= trig_cnt + 1'b1;   // wraps
                    end
                end
                TM_WAIT_DONE: begin
                    done_low <= done_low | ~done_sync;
                    if (all_done) begin
                        state <= TM_ARMED;   // rising edges here were dropped
                    end
                end
            endcase
        end
    end

    // record payload, offered the cycle after accept
    always_ff @(posedge clk125) begin
        if (accept) begin
            rec <= '{trig_num: trig_cnt, chan_en: chan_en};
        end
    end

    assign trig_arm = (state == TM_ARMED) ? chan_en : '0;   // arms channel buffers

endmodule

`default_nettype wire

// ==== logic/trig_num_fifo.sv ====
// trigger number FIFO
`timescale 1ns/1ps
`default_nettype none

module trig_num_fifo (
    input  wire                          clk125,
    input  wire                          arst_n,
    input  wire                          wr_valid,
    input  wire wfd_trig_pkg::trig_rec_t wr_rec,
    input  wire                          rd_ready,
    output logic                         wr_ready,
    output logic                         rd_valid,
    output wfd_trig_pkg::trig_rec_t      rd_rec
);
    import wfd_trig_pkg::*;

    trig_rec_t             mem [FIFO_DEPTH];   // circular buffer
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;              // 0 .. FIFO_DEPTH
    logic                  do_wr;
    logic                  do_rd;

    assign rd_valid = (count != '0);
    // full still takes a write when the reader pops on the same edge
    assign wr_ready = (count != (FIFO_PTR_W + 1)'(FIFO_DEPTH)) || rd_ready;

    assign do_wr = wr_valid & wr_ready;
    assign do_rd = rd_valid & rd_ready;

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or both
            endcase
        end
    end

    always_ff @(posedge clk125) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_rec;
        end
    end

    assign rd_rec = mem[rd_ptr];   // readable the edge after the write

endmodule

`default_nettype wire

// ==== logic/wfd_trig_pkg.sv ====
// trigger and readout shared types
`default_nettype none

package wfd_trig_pkg;

    ////////////////////
    // sizes
    localparam int NUM_CHAN   = 5;                   // channel FPGAs on the board
    localparam int TRIG_NUM_W = 24;                  // trigger counter, wraps
    localparam int FIFO_DEPTH = 8;                   // trigger records held
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int CHAN_IDX_W = 3;                   // channel index in a channel word
    localparam int WCNT_W     = 4;                   // word count in the trailer

    localparam logic [7:0] HDR_TAG = 8'hA5;          // top byte of the header word
    localparam logic [7:0] TRL_TAG = 8'h5A;          // top byte of the trailer word

    typedef logic [NUM_CHAN-1:0]   chan_mask_t;      // one bit per channel
    typedef logic [TRIG_NUM_W-1:0] trig_num_t;
    typedef logic [63:0]           daq_word_t;       // one DAQ link word

    // one trigger number FIFO entry
    typedef struct packed {
        trig_num_t  trig_num;
        chan_mask_t chan_en;                         // enables taken at accept time
    } trig_rec_t;

    ////////////////////
    // DAQ word layouts, all 64 bits
    typedef struct packed {
        logic [7:0]                            tag;
        logic [63-8-NUM_CHAN-TRIG_NUM_W:0]     rsvd;
        chan_mask_t                            chan_en;
        trig_num_t                             trig_num;
    } hdr_word_t;

    typedef struct packed {
        logic [7:0]                            tag;  // always zero
        logic [63-8-CHAN_IDX_W-TRIG_NUM_W:0]   rsvd;
        logic [CHAN_IDX_W-1:0]                 chan_idx;
        trig_num_t                             trig_num;
    } chan_word_t;

    typedef struct packed {
        logic [7:0]                            tag;
        logic [63-8-WCNT_W-TRIG_NUM_W:0]       rsvd;
        logic [WCNT_W-1:0]                     word_cnt; // header + channels + trailer
        trig_num_t                             trig_num;
    } trl_word_t;

    typedef enum logic {TM_ARMED, TM_WAIT_DONE} tm_state_t;
    typedef enum logic [1:0] {RO_IDLE, RO_HEADER, RO_CHAN, RO_TRAILER} ro_state_t;

endpackage

`default_nettype wire

// ==== logic/wfd_trig_top.sv ====
// master board trigger and readout core
`timescale 1ns/1ps
`default_nettype none

module wfd_trig_top (
    input  wire                           clk125,      // system clock
    input  wire                           arst_n,
    input  wire                           ext_trig,    // front panel trigger, async
    input  wire wfd_trig_pkg::chan_mask_t acq_dones,   // channel done lines, async
    input  wire wfd_trig_pkg::chan_mask_t chan_en,     // enabled channels
    input  wire                           daq_ready,   // from DAQ link
    output wfd_trig_pkg::chan_mask_t      acq_trigs,   // go to channel FPGAs
    output wfd_trig_pkg::chan_mask_t      trig_arm,
    output logic                          daq_valid,
    output logic                          daq_header,
    output logic                          daq_trailer,
    output wfd_trig_pkg::daq_word_t       daq_data
);
    import wfd_trig_pkg::*;

    ////////////////////
    // chain wires
    logic      rec_valid;    // tm -> fifo
    logic      rec_ready;
    trig_rec_t rec;
    logic      fifo_valid;   // fifo -> readout
    logic      fifo_ready;
    trig_rec_t fifo_rec;

    trig_manager tm (
        .clk125    (clk125),
        .arst_n    (arst_n),
        .ext_trig  (ext_trig),
        .acq_dones (acq_dones),
        .chan_en   (chan_en),
        .rec_ready (rec_ready),
        .acq_trigs (acq_trigs),
        .trig_arm  (trig_arm),
        .rec_valid (rec_valid),
        .rec       (rec)
    );

    trig_num_fifo trig_num_fifo (
        .clk125   (clk125),
        .arst_n   (arst_n),
        .wr_valid (rec_valid),
        .wr_rec   (rec),
        .rd_ready (fifo_ready),
        .wr_ready (rec_ready),
        .rd_valid (fifo_valid),
        .rd_rec   (fifo_rec)
    );

    fill_readout readout (
        .clk125      (clk125),
        .arst_n      (arst_n),
        .fifo_valid  (fifo_valid),
        .fifo_rec    (fifo_rec),
        .daq_ready   (daq_ready),
        .fifo_ready  (fifo_ready),
        .daq_valid   (daq_valid),
        .daq_header  (daq_header),
        .daq_trailer (daq_trailer),
        .daq_data    (daq_data)
    );

endmodule

`default_nettype wire

// ==== sim/wfd_trig_sva.sv ====
// go pulse and DAQ link assertions
`timescale 1ns/1ps
`default_nettype none

module wfd_trig_sva (
    input wire                           clk125,
    input wire                           arst_n,
    input wire wfd_trig_pkg::chan_mask_t acq_trigs,
    input wire wfd_trig_pkg::chan_mask_t trig_arm,
    input wire                           daq_valid,
    input wire                           daq_ready,
    input wire                           daq_header,
    input wire                           daq_trailer,
    input wire wfd_trig_pkg::daq_word_t  daq_data
);
    int fail_cnt = 0;   // read by the testbench at the end

    ////////////////////
    // go pulse
    go_one_cycle: assert property (@(posedge clk125) disable iff (!arst_n)
        (acq_trigs != '0) |=> (acq_trigs == '0))
        else begin
            fail_cnt++;
            $error("acq_trigs high for more than one cycle");
        end

    // only channels armed on the accept cycle may get go
    go_in_armed: assert property (@(posedge clk125) disable iff (!arst_n)
        (acq_trigs != '0) |-> ((acq_trigs & ~$past(trig_arm)) == '0))
        else begin
            fail_cnt++;
            $error("acq_trigs reached a channel that was not armed");
        end

    ////////////////////
    // DAQ link
    hold_on_stall: assert property (@(posedge clk125) disable iff (!arst_n)
        (daq_valid && !daq_ready) |=> (daq_valid && $stable(daq_data)
            && $stable(daq_header) && $stable(daq_trailer)))
        else begin
            fail_cnt++;
            $error("DAQ word changed while the link stalled");
        end

    flags_apart: assert property (@(posedge clk125) disable iff (!arst_n)
        !(daq_header && daq_trailer))
        else begin
            fail_cnt++;
            $error("daq_header and daq_trailer high on the same word");
        end

endmodule

bind wfd_trig_top wfd_trig_sva sva (
    .clk125      (clk125),
    .arst_n      (arst_n),
    .acq_trigs   (acq_trigs),
    .trig_arm    (trig_arm),
    .daq_valid   (daq_valid),
    .daq_ready   (daq_ready),
    .daq_header  (daq_header),
    .daq_trailer (daq_trailer),
    .daq_data    (daq_data)
);

`default_nettype wire

// ==== sim/wfd_trig_tb.sv ====
// trigger core testbench
`timescale 1ns/1ps
`default_nettype none

module wfd_trig_tb;
    import wfd_trig_pkg::*;

    localparam int SEED = 28953;

    logic        clk125 = 1'b0;
    logic        arst_n;
    logic        ext_trig;
    chan_mask_t  acq_dones;
    chan_mask_t  chan_en;
    logic        daq_ready;
    chan_mask_t  acq_trigs;
    chan_mask_t  trig_arm;
    logic        daq_valid;
    logic        daq_header;
    logic        daq_trailer;
    daq_word_t   daq_data;

    int          errors = 0;
    bit          stall = 1'b1;       // holds daq_ready low
    bit          hold_done = 1'b0;   // freezes the channel done countdown
    trig_num_t   exp_num = '0;       // next trigger number expected
    trig_rec_t   exp_recs [$];       // accepted triggers not yet read out
    logic [65:0] exp_words [$];      // {header, trailer, data} of the fill in progress

    wfd_trig_top UUT (.*);

    always #4 clk125 = ~clk125;   // 125 MHz

    task automatic check_eq(input string name, input logic [65:0] got, input logic [65:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // header, one word per enabled channel, trailer
    task automatic expect_fill(input trig_rec_t r);
        hdr_word_t  hdr;
        chan_word_t cw;
        trl_word_t  trl;
        int         nw;
        hdr = hdr_word_t'{tag: HDR_TAG, rsvd: '0, chan_en: r.chan_en, trig_num: r.trig_num};
        exp_words.push_back({2'b10, hdr});
        nw = 2;   // header and trailer
        for (int c = 0; c < NUM_CHAN; c++) begin
            if (r.chan_en[c]) begin
                cw = chan_word_t'{tag: '0, rsvd: '0, chan_idx: CHAN_IDX_W'(c),
                                  trig_num: r.trig_num};
                exp_words.push_back({2'b00, cw});
                nw++;
            end
        end
        trl = trl_word_t'{tag: TRL_TAG, rsvd: '0, word_cnt: WCNT_W'(nw), trig_num: r.trig_num};
        exp_words.push_back({2'b01, trl});
    endtask

    ////////////////////
    // channel model and DAQ sink
    initial begin : link_models
        int          done_cnt [NUM_CHAN];
        chan_mask_t  snap;           // channels of the last go
        bit          waiting;
        logic [65:0] w;
        acq_dones = '0;
        daq_ready = 1'b0;
        snap = '0;
        waiting = 1'b0;
        foreach (done_cnt[i]) done_cnt[i] = 0;
        void'($urandom(SEED));
        forever begin
            @(posedge clk125);
            #1;
            if (acq_trigs != '0) begin
                check_eq("acq_trigs", 66'(acq_trigs), 66'(chan_en));
                exp_recs.push_back(trig_rec_t'{trig_num: exp_num, chan_en: chan_en});
                exp_num = exp_num + 1'b1;   // wraps like the counter
                snap = acq_trigs;
                waiting = 1'b1;
            end
            for (int c = 0; c < NUM_CHAN; c++) begin
                if (acq_trigs[c]) begin
                    acq_dones[c] = 1'b0;   // busy until the buffer is full
                    done_cnt[c] = $urandom_range(20, 2);
                end else if (!hold_done && done_cnt[c] > 0) begin
                    done_cnt[c]--;
                    if (done_cnt[c] == 0) acq_dones[c] = 1'b1;
                end
            end
            // no re-arm while a go channel is still busy
            if (waiting && ((acq_dones & snap) != snap)) begin
                check_eq("trig_arm", 66'(trig_arm), '0);
            end else begin
                waiting = 1'b0;
            end
            daq_ready = stall ? 1'b0 : ($urandom_range(3, 0) != 0);   // stall one in four
            if (daq_valid && daq_ready) begin
                if (daq_header) begin
                    assert (exp_words.size() == 0) else begin
                        errors++;
                        $display("header at %0t before the previous fill ended", $time);
                    end
                    exp_words.delete();
                    assert (exp_recs.size() != 0) else begin
                        errors++;
                        $display("fill at %0t with no accepted trigger", $time);
                    end
                    if (exp_recs.size() != 0) expect_fill(exp_recs.pop_front());
                end
                assert (exp_words.size() != 0) else begin
                    errors++;
                    $display("DAQ word at %0t outside any fill", $time);
                end
                if (exp_words.size() != 0) begin
                    w = exp_words.pop_front();
                    check_eq("daq_header", 66'(daq_header), 66'(w[65]));
                    check_eq("daq_trailer", 66'(daq_trailer), 66'(w[64]));
                    check_eq("daq_data", 66'(daq_data), 66'(w[63:0]));
                end
            end
        end
    end

    ////////////////////
    // stimulus
    task automatic wait_armed();
        int n;
        n = 0;
        while (!(trig_arm == chan_en && chan_en != '0) && n < 200) begin
            @(posedge clk125);
            #1;
            n++;
        end
        assert (n < 200) else begin
            errors++;
            $display("manager did not re-arm within 200 cycles at %0t", $time);
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        @(negedge clk125);   // away from the model updates
        while ((exp_recs.size() != 0 || exp_words.size() != 0) && n < 3000) begin
            @(negedge clk125);
            n++;
        end
        assert (n < 3000) else begin
            errors++;
            $display("fills still missing after 3000 cycles at %0t", $time);
        end
        @(posedge clk125);
        #1;
    endtask

    // pulse ext_trig and look for go, latency is 3 to 4 cycles
    task automatic fire_trig(input bit want_go);
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        ext_trig = 1'b0;
        repeat (2) begin
            @(posedge clk125);
            #1;
        end
        ext_trig = 1'b1;
        while (n < 12 && !(want_go && seen)) begin
            @(posedge clk125);
            #1;
            n++;
            if (n == 3) ext_trig = 1'b0;
            if (acq_trigs != '0) seen = 1'b1;
        end
        ext_trig = 1'b0;
        assert (seen == want_go) else begin
            errors++;
            if (want_go) $display("no go pulse for the trigger at %0t", $time);
            else $display("ignored trigger produced a go pulse at %0t", $time);
        end
    endtask

    initial begin : stimulus
        chan_mask_t masks [6];
        masks = '{5'b11111, 5'b00001, 5'b10100, 5'b01011, 5'b10000, 5'b00110};
        arst_n = 1'b0;
        ext_trig = 1'b0;
        chan_en = 5'b11111;
        repeat (10) @(posedge clk125);
        #1;
        arst_n = 1'b1;
        @(posedge clk125);
        #1;
        check_eq("acq_trigs", 66'(acq_trigs), '0);
        check_eq("daq_valid", 66'(daq_valid), '0);
        check_eq("daq_header", 66'(daq_header), '0);
        check_eq("daq_trailer", 66'(daq_trailer), '0);
        check_eq("trig_arm", 66'(trig_arm), 66'(chan_en));
        stall = 1'b0;
        foreach (masks[k]) begin   // numbering and fill layout over several masks
            wait_armed();
            chan_en = masks[k];
            fire_trig(1'b1);
        end
        wait_armed();
        wait_drained();
        hold_done = 1'b1;   // second trigger lands in the done wait
        fire_trig(1'b1);
        fire_trig(1'b0);
        hold_done = 1'b0;
        wait_armed();
        chan_en = '0;
        fire_trig(1'b0);
        chan_en = 5'b10101;
        wait_drained();
        stall = 1'b1;   // readout holds one record, the FIFO the rest
        repeat (FIFO_DEPTH + 1) begin
            wait_armed();
            fire_trig(1'b1);
        end
        wait_armed();
        repeat (3) fire_trig(1'b0);
        check_eq("stored fills", 66'(exp_recs.size()), 66'(FIFO_DEPTH + 1));
        stall = 1'b0;
        wait_drained();
        $display("errors: testbench %0d, assertions %0d", errors, UUT.sva.fail_cnt);
        if (errors == 0 && UUT.sva.fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== wfd_trig.f ====
logic/wfd_trig_pkg.sv
logic/trig_manager.sv
logic/trig_num_fifo.sv
logic/fill_readout.sv
logic/wfd_trig_top.sv
sim/wfd_trig_sva.sv
sim/wfd_trig_tb.sv
